/* all.f */
common/frontend_pkg.sv
frontend/pc_reg.sv
frontend/bpu.sv
frontend/instbuffer.sv
frontend/frontend_top.sv
verification/tb_frontend.sv

/* verification/tb_frontend.sv */
`timescale 1ns/1ps

module tb_frontend
import frontend_pkg::*;
();

    localparam int    BTB_ENTRIES = 16;
    localparam int    IB_DEPTH    = 8;
    localparam int    IDX_W       = $clog2(BTB_ENTRIES);
    localparam int    CLK_PERIOD  = 8;
    localparam int    N_TESTS     = 5;
    localparam inst_t INST_KEY    = 32'h5a5a_0000;

    // Loop body used for predictor training
    localparam addr_t LOOP_PC       = 32'h1c00_0200;
    localparam addr_t BR_PC         = 32'h1c00_0210;
    localparam addr_t FLUSH_PC      = 32'h1c00_0800;
    localparam addr_t MISALIGNED_PC = 32'h1c00_0302;
    localparam addr_t ALIGNED_PC    = 32'h1c00_0400;

    logic        clk = 1'b0;
    logic        arst_n;
    addr_t       fetch_pc;
    logic        fetch_en;
    logic        icache_stall;
    inst_t       icache_inst;
    logic        icache_valid;
    ctrl_t       ctrl;
    addr_t       ctrl_pc;
    logic        upd_valid;
    addr_t       upd_pc;
    addr_t       upd_target;
    logic        upd_taken;
    logic        branch_flush;
    addr_t       branch_actual_addr;
    logic        send_inst_en;
    logic        out_valid;
    inst_t       out_inst;
    addr_t       out_pc;
    logic        out_pred_taken;
    addr_t       out_pred_target;
    logic        out_is_exception;
    excp_cause_t out_exception_cause;

    integer seed = 32'h126a_4735;

    // Predictor copy and expected stream state
    logic [BTB_ENTRIES-1:0] m_valid;
    addr_t                  m_tag    [BTB_ENTRIES];
    addr_t                  m_target [BTB_ENTRIES];
    ctr_t                   m_ctr    [BTB_ENTRIES];
    addr_t                  exp_pc;

    string       test_name;
    int          errors = 0;
    int          err_start = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          consumed = 0;
    int          taken_seen = 0;
    logic        hold_send;
    logic        first_pending;
    addr_t       first_pc;
    logic        first_excp;
    excp_cause_t first_cause;
    addr_t       watch_pc;
    logic        watch_seen;

    frontend_top #(
        .BTB_ENTRIES(BTB_ENTRIES),
        .IB_DEPTH(IB_DEPTH)
    ) UUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Reference predictor
    ////////////////////////////////////////////////////////////

    function automatic logic model_taken(input addr_t pc);
        logic [IDX_W-1:0] idx;
        idx = pc[IDX_W+1:2];
        return m_valid[idx] && (m_tag[idx] == pc) && (m_ctr[idx] >= 2'd2);
    endfunction

    task automatic model_update(input addr_t pc, input addr_t target, input logic taken);
        logic [IDX_W-1:0] idx;
        logic             hit;
        idx = pc[IDX_W+1:2];
        hit = m_valid[idx] && (m_tag[idx] == pc);
        if (hit && taken) begin
            if (m_ctr[idx] != 2'd3) begin
                m_ctr[idx] = m_ctr[idx] + 2'd1;
            end
            m_target[idx] = target;
        end else if (hit) begin
            if (m_ctr[idx] != 2'd0) begin
                m_ctr[idx] = m_ctr[idx] - 2'd1;
            end
        end else if (taken) begin
            m_valid[idx]  = 1'b1;
            m_tag[idx]    = pc;
            m_target[idx] = target;
            m_ctr[idx]    = 2'd2;
        end
    endtask

    task automatic value_error(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("ERROR %s: %s expected %h actual %h", test_name, what, expected, actual);
        errors++;
    endtask

    task automatic plain_error(input string msg);
        $display("Test %s: %s", test_name, msg);
        errors++;
    endtask

    // Compare one consumed entry with the expected stream
    task automatic check_entry();
        logic        taken;
        addr_t       target;
        excp_cause_t cause;
        taken  = model_taken(exp_pc);
        target = m_target[exp_pc[IDX_W+1:2]];
        cause  = (exp_pc[1:0] != 2'b00) ? EXCP_ADEF : EXCP_NONE;
        if (out_pc !== exp_pc) begin
            value_error("pc", exp_pc, out_pc);
        end
        if (out_inst !== (exp_pc ^ INST_KEY)) begin
            value_error("instruction", exp_pc ^ INST_KEY, out_inst);
        end
        if (out_pred_taken !== taken) begin
            value_error("pred_taken", taken, out_pred_taken);
        end
        if (taken && (out_pred_target !== target)) begin
            value_error("pred_target", target, out_pred_target);
        end
        if (out_is_exception !== (cause != EXCP_NONE)) begin
            value_error("exception flag", cause != EXCP_NONE, out_is_exception);
        end
        if (out_exception_cause !== cause) begin
            value_error("exception cause", cause, out_exception_cause);
        end
        if (first_pending) begin
            first_pc      = out_pc;
            first_excp    = out_is_exception;
            first_cause   = out_exception_cause;
            first_pending = 1'b0;
        end
        if (out_pc === watch_pc) begin
            watch_seen = 1'b1;
        end
        if (taken) begin
            taken_seen++;
        end
        consumed++;
        exp_pc = taken ? target : exp_pc + 32'd4;
    endtask

    ////////////////////////////////////////////////////////////
    // Cache model, random drivers and stream monitor
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        icache_valid <= arst_n && fetch_en && !icache_stall;
        icache_inst  <= fetch_pc ^ INST_KEY;
        icache_stall <= ({$random(seed)} % 5) == 0;
        send_inst_en <= !hold_send && (({$random(seed)} % 10) < 7);
    end

    always @(posedge clk) begin
        if (arst_n) begin
            if ((ctrl == CTRL_HOLD) && (out_valid || fetch_en)) begin
                plain_error("fetch or output still active during hold");
            end
            if (ctrl == CTRL_REDIRECT) begin
                exp_pc        = ctrl_pc;
                first_pending = 1'b1;
            end else if (branch_flush) begin
                exp_pc        = branch_actual_addr;
                first_pending = 1'b1;
            end else if (out_valid && send_inst_en) begin
                check_entry();
            end
            if (upd_valid) begin
                model_update(upd_pc, upd_target, upd_taken);
            end
        end
    end

    // Time budget of 200 cycles per test
    initial begin
        #(N_TESTS * 200 * CLK_PERIOD);
        $display("Watchdog expired, the run did not finish within %0d cycles", N_TESTS * 200);
        $display("tests failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    task automatic restart_fetch(input addr_t pc, input logic upd, input addr_t bpc,
                                 input addr_t tgt, input logic taken);
        @(posedge clk);
        ctrl       <= CTRL_REDIRECT;
        ctrl_pc    <= pc;
        upd_valid  <= upd;
        upd_pc     <= bpc;
        upd_target <= tgt;
        upd_taken  <= taken;
        @(posedge clk);
        ctrl      <= CTRL_RUN;
        upd_valid <= 1'b0;
    endtask

    task automatic wait_entries(input int n);
        int target;
        target = consumed + n;
        while (consumed < target) begin
            @(posedge clk);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_start = errors;
    endtask

    task automatic finish_test();
        if (errors == err_start) begin
            pass_count++;
            $display("Test %s finished: PASS", test_name);
        end else begin
            fail_count++;
            $display("Test %s finished: FAIL with %0d errors", test_name, errors - err_start);
        end
    endtask

    initial begin
        arst_n             = 1'b0;
        ctrl               = CTRL_RUN;
        ctrl_pc            = '0;
        upd_valid          = 1'b0;
        upd_pc             = '0;
        upd_target         = '0;
        upd_taken          = 1'b0;
        branch_flush       = 1'b0;
        branch_actual_addr = '0;
        send_inst_en       = 1'b0;
        icache_stall       = 1'b0;
        icache_inst        = '0;
        icache_valid       = 1'b0;
        hold_send          = 1'b0;
        m_valid            = '0;
        exp_pc             = RESET_PC;
        first_pending      = 1'b0;
        watch_pc           = '0;
        watch_seen         = 1'b0;
        start_test("sequential_fetch");
        repeat (3) @(posedge clk);

        // State held by reset
        if (fetch_pc !== RESET_PC) begin
            value_error("fetch_pc in reset", RESET_PC, fetch_pc);
        end
        if (fetch_en !== 1'b0) begin
            value_error("fetch_en in reset", 32'd0, fetch_en);
        end
        if (out_valid !== 1'b0) begin
            value_error("out_valid in reset", 32'd0, out_valid);
        end
        arst_n <= 1'b1;

        wait_entries(24);
        finish_test();

        // Backward branch forms a five-entry loop once trained
        start_test("predictor_training");
        restart_fetch(LOOP_PC, 1'b1, BR_PC, LOOP_PC, 1'b1);
        restart_fetch(LOOP_PC, 1'b1, BR_PC, LOOP_PC, 1'b1);
        taken_seen = 0;
        while (taken_seen < 3) begin
            @(posedge clk);
        end
        restart_fetch(LOOP_PC, 1'b1, BR_PC, LOOP_PC, 1'b0);
        restart_fetch(LOOP_PC, 1'b1, BR_PC, LOOP_PC, 1'b0);
        watch_pc   = BR_PC + 32'd4;
        watch_seen = 1'b0;
        wait_entries(10);
        if (!watch_seen) begin
            plain_error("sequential flow did not return after not-taken training");
        end
        finish_test();

        start_test("branch_flush");
        wait_entries(4);
        repeat (int'({$random(seed)} % 12)) @(posedge clk);
        @(posedge clk);
        branch_flush       <= 1'b1;
        branch_actual_addr <= FLUSH_PC;
        @(posedge clk);
        branch_flush <= 1'b0;
        wait_entries(8);
        if (first_pc !== FLUSH_PC) begin
            value_error("first pc after flush", FLUSH_PC, first_pc);
        end
        finish_test();

        start_test("redirect_exception");
        restart_fetch(MISALIGNED_PC, 1'b0, '0, '0, 1'b0);
        wait_entries(4);
        if (first_pc !== MISALIGNED_PC) begin
            value_error("first pc after redirect", MISALIGNED_PC, first_pc);
        end
        if (first_excp !== 1'b1) begin
            value_error("exception flag", 32'd1, first_excp);
        end
        if (first_cause !== EXCP_ADEF) begin
            value_error("exception cause", EXCP_ADEF, first_cause);
        end
        restart_fetch(ALIGNED_PC, 1'b0, '0, '0, 1'b0);
        wait_entries(6);
        if (first_pc !== ALIGNED_PC) begin
            value_error("first pc after redirect", ALIGNED_PC, first_pc);
        end
        if (first_excp !== 1'b0) begin
            value_error("exception flag", 32'd0, first_excp);
        end
        finish_test();

        // Buffer fills up, then hold freezes everything
        start_test("backpressure_hold");
        hold_send <= 1'b1;
        repeat (40) @(posedge clk);
        if (fetch_en) begin
            plain_error("fetch still enabled with a full buffer");
        end
        if (!out_valid) begin
            plain_error("buffer empty after a long back-pressure stretch");
        end
        ctrl      <= CTRL_HOLD;
        hold_send <= 1'b0;
        repeat (12) @(posedge clk);
        ctrl <= CTRL_RUN;
        wait_entries(20);
        finish_test();

        $display("Pass count %0d, fail count %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* frontend/frontend_top.sv */
`timescale 1ns/1ps

module frontend_top
import frontend_pkg::*;
#(
    parameter int BTB_ENTRIES = 16,
    parameter int IB_DEPTH    = 8
)
(
    input  logic        clk,
    input  logic        arst_n,

    // Instruction cache
    output addr_t       fetch_pc,
    output logic        fetch_en,
    input  logic        icache_stall,
    input  inst_t       icache_inst,
    input  logic        icache_valid,

    // Backend control and predictor training
    input  ctrl_t       ctrl,
    input  addr_t       ctrl_pc,
    input  logic        upd_valid,
    input  addr_t       upd_pc,
    input  addr_t       upd_target,
    input  logic        upd_taken,
    input  logic        branch_flush,
    input  addr_t       branch_actual_addr,
    input  logic        send_inst_en,

    // Instruction stream to the backend
    output logic        out_valid,
    output inst_t       out_inst,
    output addr_t       out_pc,
    output logic        out_pred_taken,
    output addr_t       out_pred_target,
    output logic        out_is_exception,
    output excp_cause_t out_exception_cause
);

    logic        pred_taken;
    addr_t       pred_target;
    logic        fetch_issue;
    logic        buf_stall;
    logic        is_exception;
    excp_cause_t exception_cause;

    pc_reg u_pc_reg (
        .clk,
        .arst_n,
        .icache_stall,
        .buf_stall,
        .ctrl,
        .ctrl_pc,
        .branch_flush,
        .branch_actual_addr,
        .pred_taken,
        .pred_target,
        .fetch_pc,
        .fetch_en,
        .fetch_issue,
        .is_exception,
        .exception_cause
    );

    bpu #(
        .BTB_ENTRIES(BTB_ENTRIES)
    ) u_bpu (
        .clk,
        .arst_n,
        .fetch_pc,
        .upd_valid,
        .upd_pc,
        .upd_target,
        .upd_taken,
        .pred_taken,
        .pred_target
    );

    instbuffer #(
        .IB_DEPTH(IB_DEPTH)
    ) u_instbuffer (
        .clk,
        .arst_n,
        .ctrl,
        .branch_flush,
        .fetch_issue,
        .fetch_pc,
        .pred_taken,
        .pred_target,
        .is_exception,
        .exception_cause,
        .icache_inst,
        .icache_valid,
        .send_inst_en,
        .buf_stall,
        .out_valid,
        .out_inst,
        .out_pc,
        .out_pred_taken,
        .out_pred_target,
        .out_is_exception,
        .out_exception_cause
    );

endmodule

/* frontend/instbuffer.sv */
`timescale 1ns/1ps

module instbuffer
import frontend_pkg::*;
#(
    parameter int IB_DEPTH = 8
)
(
    input  logic        clk,
    input  logic        arst_n,

    input  ctrl_t       ctrl,
    input  logic        branch_flush,

    // Metadata of the fetch going out this cycle
    input  logic        fetch_issue,
    input  addr_t       fetch_pc,
    input  logic        pred_taken,
    input  addr_t       pred_target,
    input  logic        is_exception,
    input  excp_cause_t exception_cause,

    // Cache response, one cycle after issue
    input  inst_t       icache_inst,
    input  logic        icache_valid,

    input  logic        send_inst_en,

    output logic        buf_stall,
    output logic        out_valid,
    output inst_t       out_inst,
    output addr_t       out_pc,
    output logic        out_pred_taken,
    output addr_t       out_pred_target,
    output logic        out_is_exception,
    output excp_cause_t out_exception_cause
);

    localparam int PTR_W = $clog2(IB_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    // Fewer than two free slots
    localparam logic [CNT_W-1:0] STALL_LEVEL = CNT_W'(IB_DEPTH - 1);

    logic flush_any;

    assign flush_any = branch_flush || (ctrl == CTRL_REDIRECT);

    ////////////////////////////////////////////////////////////
    // In-flight fetch metadata
    ////////////////////////////////////////////////////////////

    logic        meta_valid_q;
    logic        meta_kill_q;
    addr_t       meta_pc;
    logic        meta_pred_taken;
    addr_t       meta_pred_target;
    logic        meta_excp;
    excp_cause_t meta_cause;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            meta_valid_q <= 1'b0;
            meta_kill_q  <= 1'b0;
        end else begin
            meta_valid_q <= fetch_issue;
            // Wrong path if issued alongside a flush or redirect
            meta_kill_q  <= flush_any;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_issue) begin
            meta_pc          <= fetch_pc;
            meta_pred_taken  <= pred_taken;
            meta_pred_target <= pred_target;
            meta_excp        <= is_exception;
            meta_cause       <= exception_cause;
        end
    end

    ////////////////////////////////////////////////////////////
    // FIFO toward the backend
    ////////////////////////////////////////////////////////////

    inst_t       mem_inst        [IB_DEPTH];
    addr_t       mem_pc          [IB_DEPTH];
    logic        mem_pred_taken  [IB_DEPTH];
    addr_t       mem_pred_target [IB_DEPTH];
    logic        mem_excp        [IB_DEPTH];
    excp_cause_t mem_cause       [IB_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    // Responses that belong to a flushed path never enter
    assign wr_en = icache_valid && meta_valid_q && !meta_kill_q && !flush_any;

    // Outputs frozen during hold and while the stream is being flushed
    assign out_valid = (count != '0) && (ctrl == CTRL_RUN) && !branch_flush;
    assign rd_en     = out_valid && send_inst_en;
    assign buf_stall = (count >= STALL_LEVEL);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush_any) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_inst[wr_ptr]        <= icache_inst;
            mem_pc[wr_ptr]          <= meta_pc;
            mem_pred_taken[wr_ptr]  <= meta_pred_taken;
            mem_pred_target[wr_ptr] <= meta_pred_target;
            mem_excp[wr_ptr]        <= meta_excp;
            mem_cause[wr_ptr]       <= meta_cause;
        end
    end

    assign out_inst            = mem_inst[rd_ptr];
    assign out_pc              = mem_pc[rd_ptr];
    assign out_pred_taken      = mem_pred_taken[rd_ptr];
    assign out_pred_target     = mem_pred_target[rd_ptr];
    assign out_is_exception    = mem_excp[rd_ptr];
    assign out_exception_cause = mem_cause[rd_ptr];

endmodule

/* frontend/bpu.sv */
`timescale 1ns/1ps

module bpu
import frontend_pkg::*;
#(
    parameter int BTB_ENTRIES = 16
)
(
    input  logic  clk,
    input  logic  arst_n,

    input  addr_t fetch_pc,

    input  logic  upd_valid,
    input  addr_t upd_pc,
    input  addr_t upd_target,
    input  logic  upd_taken,

    output logic  pred_taken,
    output addr_t pred_target
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);

    typedef logic [IDX_W-1:0] idx_t;

    ////////////////////////////////////////////////////////////
    // Table storage
    ////////////////////////////////////////////////////////////

    logic [BTB_ENTRIES-1:0] tbl_valid;
    addr_t                  tbl_tag    [BTB_ENTRIES];
    addr_t                  tbl_target [BTB_ENTRIES];
    ctr_t                   tbl_ctr    [BTB_ENTRIES];

    idx_t rd_idx;
    idx_t wr_idx;
    logic rd_hit;
    logic wr_hit;
    ctr_t ctr_next;

    // Word-aligned index, full pc as tag
    assign rd_idx = fetch_pc[IDX_W+1:2];
    assign wr_idx = upd_pc[IDX_W+1:2];

    ////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////

    assign rd_hit      = tbl_valid[rd_idx] && (tbl_tag[rd_idx] == fetch_pc);
    assign pred_taken  = rd_hit && (tbl_ctr[rd_idx] >= CTR_WEAK_TAKEN);
    assign pred_target = rd_hit ? tbl_target[rd_idx] : '0;

    ////////////////////////////////////////////////////////////
    // Training
    ////////////////////////////////////////////////////////////

    assign wr_hit = tbl_valid[wr_idx] && (tbl_tag[wr_idx] == upd_pc);

    // Saturating step toward the resolved direction
    always_comb begin
        ctr_next = tbl_ctr[wr_idx];
        if (upd_taken) begin
            if (tbl_ctr[wr_idx] != CTR_MAX) begin
                ctr_next = tbl_ctr[wr_idx] + ctr_t'(1);
            end
        end else begin
            if (tbl_ctr[wr_idx] != CTR_MIN) begin
                ctr_next = tbl_ctr[wr_idx] - ctr_t'(1);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tbl_valid <= '0;
        end else if (upd_valid && !wr_hit && upd_taken) begin
            tbl_valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_valid) begin
            if (wr_hit) begin
                tbl_ctr[wr_idx] <= ctr_next;
                if (upd_taken) begin
                    tbl_target[wr_idx] <= upd_target;
                end
            end else if (upd_taken) begin
                // Miss on a taken branch allocates weakly taken
                tbl_tag[wr_idx]    <= upd_pc;
                tbl_target[wr_idx] <= upd_target;
                tbl_ctr[wr_idx]    <= CTR_WEAK_TAKEN;
            end
        end
    end

endmodule

/* frontend/pc_reg.sv */
`timescale 1ns/1ps

module pc_reg
import frontend_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,

    input  logic        icache_stall,
    input  logic        buf_stall,

    input  ctrl_t       ctrl,
    input  addr_t       ctrl_pc,
    input  logic        branch_flush,
    input  addr_t       branch_actual_addr,

    input  logic        pred_taken,
    input  addr_t       pred_target,

    output addr_t       fetch_pc,
    output logic        fetch_en,
    output logic        fetch_issue,
    output logic        is_exception,
    output excp_cause_t exception_cause
);

    logic  started_q;
    addr_t pc_next;

    // Goes high on the first edge after reset and stays there
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            started_q <= 1'b0;
        end else begin
            started_q <= 1'b1;
        end
    end

    // No fetch while held by the backend or while the buffer is nearly full
    assign fetch_en    = started_q && (ctrl != CTRL_HOLD) && !buf_stall;
    assign fetch_issue = fetch_en && !icache_stall;

    ////////////////////////////////////////////////////////////
    // Next fetch address
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (ctrl == CTRL_REDIRECT) begin
            pc_next = ctrl_pc;
        end else if (branch_flush) begin
            pc_next = branch_actual_addr;
        end else if (!fetch_issue) begin
            pc_next = fetch_pc;
        end else if (pred_taken) begin
            pc_next = pred_target;
        end else begin
            pc_next = fetch_pc + PC_STEP;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_pc <= RESET_PC;
        end else begin
            fetch_pc <= pc_next;
        end
    end

    // Misaligned address is flagged but the fetch still goes out
    assign is_exception    = |fetch_pc[1:0];
    assign exception_cause = is_exception ? EXCP_ADEF : EXCP_NONE;

endmodule

/* common/frontend_pkg.sv */
package frontend_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int ADDR_W = 32;
    localparam int INST_W = 32;

    // Address and instruction words
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [INST_W-1:0] inst_t;

    // Byte distance between two sequential fetches
    localparam addr_t PC_STEP = 32'd4;

    // First fetch address after reset
    localparam addr_t RESET_PC = 32'h1c00_0000;

    ////////////////////////////////////////////////////////////
    // Fetch exceptions
    ////////////////////////////////////////////////////////////

    typedef logic [1:0] excp_cause_t;

    localparam excp_cause_t EXCP_NONE = 2'd0;
    // Misaligned fetch address
    localparam excp_cause_t EXCP_ADEF = 2'd1;

    ////////////////////////////////////////////////////////////
    // Branch predictor state
    ////////////////////////////////////////////////////////////

    // 2-bit saturating counter, taken when 2 or 3
    typedef logic [1:0] ctr_t;

    localparam ctr_t CTR_MIN        = 2'd0;
    localparam ctr_t CTR_WEAK_TAKEN = 2'd2;
    localparam ctr_t CTR_MAX        = 2'd3;

    ////////////////////////////////////////////////////////////
    // Backend control of the frontend
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        CTRL_RUN      = 2'd0,
        CTRL_HOLD     = 2'd1,
        CTRL_REDIRECT = 2'd2
    } ctrl_t;

endpackage
